/* huff_defines.svh */
// **************************************************************************
// shared sizes and fixed code table addresses for the huffman encoder
// input FIFO depth, code table depth, ZRL and EOB addresses and the DC
// marker nibble inside the AC table
// **************************************************************************
`ifndef HUFF_DEFINES_SVH
`define HUFF_DEFINES_SVH

// words held by the input FIFO, producer must stay below this
`define HUFF_FIFO_DEPTH 64

// code table entries, lower half luma, upper half chroma
`define HUFF_TAB_DEPTH 512

`define HUFF_ADDR_ZRL 8'hF0      // sixteen zeros code, low address byte
`define HUFF_ADDR_EOB 8'h00      // end of block code, low address byte
`define HUFF_DC_LOW_NIBBLE 4'hF  // DC sizes live in unused AC slots x_F

`endif

/* huff_word_pkg.sv */
// **************************************************************************
// input word format of the huffman encoder
// raw word, coefficient, zero run and ZRL count field types
// **************************************************************************
package huff_word_pkg;

  // [15]    1 coefficient, 0 run or EOB
  // [14]    DC when coefficient, else AC
  // [13]    chroma table select (DC only)
  // [12]    last block (DC), last word of block (AC), EOB (non coefficient)
  // [11:0]  signed coefficient
  // [5:4]   ZRL count on run words
  // [3:0]   zero run on run words
  typedef logic [15:0] in_word_t;

  typedef logic signed [11:0] coef_t;  // word bits 11..0

  typedef logic [3:0] run_t;           // zeros before the next AC

  typedef logic [1:0] zrl_cnt_t;       // F0 codes to send first

endpackage

/* huff_code_pkg.sv */
// **************************************************************************
// code side types of the huffman encoder
// code bits, token length, table address and entry, sequencer states
// **************************************************************************
package huff_code_pkg;

  typedef logic [15:0] code_bits_t;  // right aligned
  typedef logic [3:0]  code_len_t;   // 0 stands for 16 bits

  // [8] table select (1 chroma), [7:0] code index
  typedef logic [8:0]  tab_addr_t;

  // [19:16] code length, [15:0] code bits
  typedef logic [19:0] tab_entry_t;

  typedef enum logic [2:0] {
    SEQ_IDLE,    // waiting for a word
    SEQ_ZRL,     // read sixteen zeros code
    SEQ_LOOKUP,  // read DC, AC or EOB code
    SEQ_CODE,    // table token out
    SEQ_VALUE    // coefficient bits out
  } seq_state_t;

endpackage

/* huff_in_fifo.sv */
// **************************************************************************
// input FIFO of the huffman encoder
// circular buffer written by strobe, head word shown until popped
// **************************************************************************
`timescale 1ns/10ps
`include "huff_defines.svh"

module huff_in_fifo (
  input  logic                  xclk2x,
  input  logic                  rst_n_i,
  input  logic                  ds_i,         // write strobe
  input  huff_word_pkg::in_word_t di_i,
  input  logic                  pop_i,        // head leaves at this edge
  output huff_word_pkg::in_word_t head_o,
  output logic                  not_empty_o
);

  localparam int PW = $clog2(`HUFF_FIFO_DEPTH);

  huff_word_pkg::in_word_t mem [`HUFF_FIFO_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [PW:0]   count;  // one extra bit so full is representable

  always_ff @(posedge xclk2x) begin
    if (ds_i) mem[wr_ptr] <= di_i;  // storage is never cleared
  end

  always_ff @(posedge xclk2x) begin
    if (!rst_n_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (ds_i) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop_i) rd_ptr <= rd_ptr + 1'b1;
      case ({ds_i, pop_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;        // both or none
      endcase
    end
  end

  assign head_o      = mem[rd_ptr];     // valid one cycle after first write
  assign not_empty_o = (count != '0);

endmodule

/* huff_sequencer.sv */
// **************************************************************************
// word sequencer of the huffman encoder
// pops and classifies words, sends ZRL codes, sizes coefficients,
// addresses the code table and strobes code and value tokens
// **************************************************************************
`timescale 1ns/10ps
`include "huff_defines.svh"

module huff_sequencer (
  input  logic                     xclk2x,
  input  logic                     rst_n_i,
  input  huff_word_pkg::in_word_t  head_i,
  input  logic                     not_empty_i,
  input  logic                     busy_i,        // out stage holds a token
  output logic                     pop_o,
  output logic                     rd_en_o,
  output huff_code_pkg::tab_addr_t rd_addr_o,
  output logic                     code_strobe_o,
  output logic                     val_strobe_o,
  output huff_code_pkg::code_bits_t val_bits_o,
  output huff_code_pkg::code_len_t val_len_o,
  output logic                     blk_last_o,
  output logic                     last_blk_seen_o
);

  huff_code_pkg::seq_state_t state;
  huff_word_pkg::coef_t      coef;
  huff_word_pkg::run_t       run;
  huff_word_pkg::zrl_cnt_t   zrl_cnt;
  huff_code_pkg::code_len_t  size;
  logic        sel;       // chroma, latched from DC word
  logic        word_dc;
  logic        word_ac;
  logic        word_end;  // EOB or last AC of a block
  logic        last_blk;
  logic        zrl_tok;   // current table token is F0
  logic        go;
  logic        has_val;
  logic        fin;       // last token of the current word
  logic [11:0] mag;
  logic [11:0] val_raw;
  logic [11:0] mask;

  // magnitude size, -2048 lands on bit 11 and gives 12
  always_comb begin
    mag  = coef[11] ? 12'(-coef) : coef;
    size = '0;
    for (int i = 0; i < 12; i++) begin
      if (mag[i]) size = 4'(i + 1);
    end
  end

  assign val_raw = coef[11] ? 12'(coef - 12'sd1) : coef;  // ones complement for negatives
  assign mask    = 12'((13'd1 << size) - 13'd1);

  assign go      = !busy_i;
  assign has_val = (word_dc || word_ac) && (size != '0);

  assign pop_o         = go && (state == huff_code_pkg::SEQ_IDLE) && not_empty_i;
  assign rd_en_o       = go && ((state == huff_code_pkg::SEQ_ZRL) ||
                                (state == huff_code_pkg::SEQ_LOOKUP));
  assign code_strobe_o = go && (state == huff_code_pkg::SEQ_CODE);
  assign val_strobe_o  = go && (state == huff_code_pkg::SEQ_VALUE);
  assign val_bits_o    = {4'b0, val_raw & mask};
  assign val_len_o     = size;

  assign fin             = (code_strobe_o && !zrl_tok && !has_val) || val_strobe_o;
  assign blk_last_o      = fin && word_end && last_blk;
  assign last_blk_seen_o = pop_o && head_i[15] && head_i[14] && head_i[12];

  always_comb begin
    if (state == huff_code_pkg::SEQ_ZRL) rd_addr_o = {sel, `HUFF_ADDR_ZRL};
    else if (word_dc)                    rd_addr_o = {sel, size, `HUFF_DC_LOW_NIBBLE};
    else if (word_ac)                    rd_addr_o = {sel, run, size};
    else                                 rd_addr_o = {sel, `HUFF_ADDR_EOB};
  end

  always_ff @(posedge xclk2x) begin
    if (!rst_n_i) begin
      state    <= huff_code_pkg::SEQ_IDLE;
      run      <= '0;
      zrl_cnt  <= '0;
      sel      <= 1'b0;
      word_dc  <= 1'b0;
      word_ac  <= 1'b0;
      word_end <= 1'b0;
      last_blk <= 1'b0;
      zrl_tok  <= 1'b0;
    end else if (go) begin  // everything freezes while the out stage is busy
      case (state)
        huff_code_pkg::SEQ_IDLE: if (not_empty_i) begin
          word_dc  <= head_i[15] && head_i[14];
          word_ac  <= head_i[15] && !head_i[14];
          word_end <= !head_i[14] && head_i[12];
          if (head_i[15]) begin
            if (head_i[14]) begin
              sel <= head_i[13];
              if (head_i[12]) last_blk <= 1'b1;
            end
            state <= huff_code_pkg::SEQ_LOOKUP;
          end else if (!head_i[12]) begin  // run word, only stores
            run     <= head_i[3:0];
            zrl_cnt <= head_i[5:4];
            if (head_i[5:4] != 2'b00) state <= huff_code_pkg::SEQ_ZRL;
          end else begin
            state <= huff_code_pkg::SEQ_LOOKUP;  // EOB
          end
        end
        huff_code_pkg::SEQ_ZRL: begin
          zrl_cnt <= zrl_cnt - 1'b1;
          zrl_tok <= 1'b1;
          state   <= huff_code_pkg::SEQ_CODE;
        end
        huff_code_pkg::SEQ_LOOKUP: begin
          zrl_tok <= 1'b0;
          if (word_ac) run <= '0;  // run used once
          state <= huff_code_pkg::SEQ_CODE;
        end
        huff_code_pkg::SEQ_CODE: begin
          if (zrl_tok) begin
            state <= (zrl_cnt != '0) ? huff_code_pkg::SEQ_ZRL : huff_code_pkg::SEQ_IDLE;
          end else if (has_val) begin
            state <= huff_code_pkg::SEQ_VALUE;
          end else begin
            state <= huff_code_pkg::SEQ_IDLE;
          end
        end
        default: state <= huff_code_pkg::SEQ_IDLE;  // SEQ_VALUE
      endcase
      if (blk_last_o) last_blk <= 1'b0;
    end
  end

  always_ff @(posedge xclk2x) begin
    if (pop_o && head_i[15]) coef <= head_i[11:0];
  end

endmodule

/* huff_code_table.sv */
// **************************************************************************
// huffman code table RAM
// direct write port, registered read enabled per lookup
// **************************************************************************
`timescale 1ns/10ps
`include "huff_defines.svh"

module huff_code_table (
  input  logic                      xclk2x,
  input  logic                      twe_i,
  input  huff_code_pkg::tab_addr_t  ta_i,
  input  huff_code_pkg::tab_entry_t tdi_i,
  input  logic                      rd_en_i,
  input  huff_code_pkg::tab_addr_t  rd_addr_i,
  output huff_code_pkg::tab_entry_t rd_data_o   // holds until next read
);

  huff_code_pkg::tab_entry_t mem [`HUFF_TAB_DEPTH];

  always_ff @(posedge xclk2x) begin
    if (twe_i) mem[ta_i] <= tdi_i;  // loaded by software before use
  end

  always_ff @(posedge xclk2x) begin
    if (rd_en_i) rd_data_o <= mem[rd_addr_i];
  end

endmodule

/* huff_out_stage.sv */
// **************************************************************************
// output stage of the huffman encoder
// token register held under back pressure, last block tracking and
// flush request after the final token
// **************************************************************************
`timescale 1ns/10ps

module huff_out_stage (
  input  logic                      xclk2x,
  input  logic                      rst_n_i,
  input  logic                      rdy_i,           // stuffer accepts
  input  logic                      code_strobe_i,
  input  huff_code_pkg::tab_entry_t tab_data_i,
  input  logic                      val_strobe_i,
  input  huff_code_pkg::code_bits_t val_bits_i,
  input  huff_code_pkg::code_len_t  val_len_i,
  input  logic                      blk_last_i,
  input  logic                      last_blk_seen_i,
  output logic                      busy_o,
  output huff_code_pkg::code_bits_t do_o,
  output huff_code_pkg::code_len_t  dl_o,
  output logic                      dv_o,
  output logic                      flush_o,
  output logic                      last_block_o
);

  logic hold;        // token still waiting for the stuffer
  logic flush_pend;  // final token loaded, flush not yet taken
  logic load;

  assign hold   = dv_o && !rdy_i;
  assign load   = !hold && (code_strobe_i || val_strobe_i);
  assign busy_o = hold || flush_pend;  // no new block until flush is done

  always_ff @(posedge xclk2x) begin
    if (load) begin
      do_o <= code_strobe_i ? tab_data_i[15:0]  : val_bits_i;
      dl_o <= code_strobe_i ? tab_data_i[19:16] : val_len_i;
    end
  end

  always_ff @(posedge xclk2x) begin
    if (!rst_n_i) begin
      dv_o         <= 1'b0;
      flush_o      <= 1'b0;
      flush_pend   <= 1'b0;
      last_block_o <= 1'b0;
    end else begin
      if (!hold) dv_o <= code_strobe_i || val_strobe_i;
      if (flush_o) flush_o <= !rdy_i;       // kept until the stuffer takes it
      else         flush_o <= flush_pend && !dv_o;
      if (flush_o && rdy_i) begin
        flush_pend   <= 1'b0;
        last_block_o <= 1'b0;
      end else begin
        if (blk_last_i)      flush_pend   <= 1'b1;
        if (last_blk_seen_i) last_block_o <= 1'b1;
      end
    end
  end

endmodule

/* huffman_enc.sv */
// **************************************************************************
// JPEG huffman entropy encoder, top level
// input FIFO, word sequencer, code table and output stage
// **************************************************************************
`timescale 1ns/10ps

module huffman_enc (
  input  logic                      xclk2x,
  input  logic                      rst_n_i,
  input  logic                      ds_i,
  input  huff_word_pkg::in_word_t   di_i,
  input  logic                      rdy_i,
  input  logic                      twe_i,
  input  huff_code_pkg::tab_addr_t  ta_i,
  input  huff_code_pkg::tab_entry_t tdi_i,
  output huff_code_pkg::code_bits_t do_o,
  output huff_code_pkg::code_len_t  dl_o,
  output logic                      dv_o,
  output logic                      flush_o,
  output logic                      last_block_o
);

  huff_word_pkg::in_word_t   head;
  huff_code_pkg::tab_addr_t  rd_addr;
  huff_code_pkg::tab_entry_t rd_data;
  huff_code_pkg::code_bits_t val_bits;
  huff_code_pkg::code_len_t  val_len;
  logic not_empty;
  logic pop;
  logic rd_en;
  logic code_strobe;
  logic val_strobe;
  logic blk_last;
  logic last_blk_seen;
  logic busy;

  huff_in_fifo i_huff_in_fifo (
    .xclk2x      (xclk2x),
    .rst_n_i     (rst_n_i),
    .ds_i        (ds_i),
    .di_i        (di_i),
    .pop_i       (pop),
    .head_o      (head),
    .not_empty_o (not_empty)
  );

  huff_sequencer i_huff_sequencer (
    .xclk2x          (xclk2x),
    .rst_n_i         (rst_n_i),
    .head_i          (head),
    .not_empty_i     (not_empty),
    .busy_i          (busy),
    .pop_o           (pop),
    .rd_en_o         (rd_en),
    .rd_addr_o       (rd_addr),
    .code_strobe_o   (code_strobe),
    .val_strobe_o    (val_strobe),
    .val_bits_o      (val_bits),
    .val_len_o       (val_len),
    .blk_last_o      (blk_last),
    .last_blk_seen_o (last_blk_seen)
  );

  huff_code_table i_huff_code_table (
    .xclk2x    (xclk2x),
    .twe_i     (twe_i),
    .ta_i      (ta_i),
    .tdi_i     (tdi_i),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  huff_out_stage i_huff_out_stage (
    .xclk2x          (xclk2x),
    .rst_n_i         (rst_n_i),
    .rdy_i           (rdy_i),
    .code_strobe_i   (code_strobe),
    .tab_data_i      (rd_data),
    .val_strobe_i    (val_strobe),
    .val_bits_i      (val_bits),
    .val_len_i       (val_len),
    .blk_last_i      (blk_last),
    .last_blk_seen_i (last_blk_seen),
    .busy_o          (busy),
    .do_o            (do_o),
    .dl_o            (dl_o),
    .dv_o            (dv_o),
    .flush_o         (flush_o),
    .last_block_o    (last_block_o)
  );

endmodule

/* huffman_enc_sva.sv */
// **************************************************************************
// output protocol assertions for the huffman encoder
// hold under back pressure, flush against tokens, reset values
// **************************************************************************
`timescale 1ns/10ps

module huffman_enc_sva (
  input logic        xclk2x,
  input logic        rst_n_i,
  input logic        rdy_i,
  input logic [15:0] do_o,
  input logic [3:0]  dl_o,
  input logic        dv_o,
  input logic        flush_o,
  input logic        last_block_o
);

  // a pending token keeps its value until the stuffer takes it
  a_hold: assert property (@(posedge xclk2x) disable iff (!rst_n_i)
    (dv_o && !rdy_i) |=> ($stable(do_o) && $stable(dl_o) && dv_o))
    else $error("token changed while stalled");

  a_flush_excl: assert property (@(posedge xclk2x) disable iff (!rst_n_i)
    !(flush_o && dv_o))
    else $error("flush together with a token");

  a_flush_last: assert property (@(posedge xclk2x) disable iff (!rst_n_i)
    $rose(flush_o) |-> last_block_o)
    else $error("flush outside the last block");

  a_reset: assert property (@(posedge xclk2x)
    !rst_n_i |=> (!dv_o && !flush_o && !last_block_o))
    else $error("control outputs high after reset");

endmodule

bind huffman_enc huffman_enc_sva i_huffman_enc_sva (
  .xclk2x (xclk2x), .rst_n_i (rst_n_i), .rdy_i (rdy_i), .do_o (do_o), .dl_o (dl_o),
  .dv_o (dv_o), .flush_o (flush_o), .last_block_o (last_block_o)
);

/* tb_huffman_enc.sv */
// **************************************************************************
// testbench for the huffman encoder top level
// code table load, block stimulus, reference token model, compare
// process with random back pressure, flush check and watchdog
// **************************************************************************
`timescale 1ns/10ps
`include "huff_defines.svh"

module tb_huffman_enc;

  logic        xclk2x;
  logic        rst_n_i;
  logic        ds_i;
  logic [15:0] di_i;
  logic        rdy_i;
  logic        twe_i;
  logic [8:0]  ta_i;
  logic [19:0] tdi_i;
  logic [15:0] do_o;
  logic [3:0]  dl_o;
  logic        dv_o;
  logic        flush_o;
  logic        last_block_o;

  logic [19:0] tab_img [0:511];  // testbench copy of the code table
  logic [19:0] exp_q[$];         // expected {len, bits} tokens
  logic        exp_lb_q[$];      // expected last_block_o per token
  logic [15:0] stim_q[$];
  int          blk_len_q[$];
  int          total_words = 0;
  int          err_cnt = 0;
  int          check_cnt = 0;
  logic        load_done = 1'b0;
  logic        flush_taken = 1'b0;  // flush accepted at the edge after it was set
  logic [31:0] rnd = 32'h6cd3;
  logic [31:0] rdy_rnd = 32'h6cd3;  // own stream for back pressure
  logic        m_sel = 1'b0;        // model table select
  logic [3:0]  m_run = 4'h0;        // model stored run
  logic        m_last = 1'b0;       // model in last block

  huffman_enc i_huffman_enc (
    .xclk2x (xclk2x), .rst_n_i (rst_n_i), .ds_i (ds_i), .di_i (di_i), .rdy_i (rdy_i),
    .twe_i (twe_i), .ta_i (ta_i), .tdi_i (tdi_i), .do_o (do_o), .dl_o (dl_o),
    .dv_o (dv_o), .flush_o (flush_o), .last_block_o (last_block_o)
  );

  always #5 xclk2x = ~xclk2x;  // 10 ns period

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] dc_word(input int c, input logic chroma, input logic last);
    logic [11:0] cb;
    cb = 12'(c);
    return {2'b11, chroma, last, cb};
  endfunction

  function automatic logic [15:0] ac_word(input int c);
    logic [11:0] cb;
    cb = 12'(c);
    return {4'b1000, cb};
  endfunction

  function automatic logic [15:0] run_word(input logic [1:0] zrl, input logic [3:0] run);
    return {10'b0, zrl, run};
  endfunction

  function automatic void push_token(input logic [19:0] t);
    exp_q.push_back(t);
    exp_lb_q.push_back(m_last);
  endfunction

  // expected tokens of one input word
  function automatic void model_word(input logic [15:0] w);
    logic signed [11:0] c;
    int          v;
    int          mag;
    int          sz;
    logic [8:0]  a;
    logic [15:0] vb;
    if (w[15]) begin
      c   = w[11:0];
      v   = c;
      mag = (v < 0) ? -v : v;
      sz  = 0;
      while (mag > 0) begin  // bits needed for the magnitude
        sz  = sz + 1;
        mag = mag >> 1;
      end
      if (w[14]) begin
        m_sel = w[13];       // select holds for the whole block
        if (w[12]) m_last = 1'b1;
        a = {m_sel, sz[3:0], `HUFF_DC_LOW_NIBBLE};
      end else begin
        a     = {m_sel, m_run, sz[3:0]};
        m_run = 4'h0;        // run is used once
      end
      push_token(tab_img[a]);
      if (sz > 0) begin
        vb = (v < 0) ? 16'(v - 1) : 16'(v);  // negatives sent as value minus one
        vb = vb & 16'((1 << sz) - 1);
        push_token({sz[3:0], vb});
      end
    end else if (!w[12]) begin
      m_run = w[3:0];
      for (int i = 0; i < int'(w[5:4]); i++) push_token(tab_img[{m_sel, `HUFF_ADDR_ZRL}]);
    end else begin
      push_token(tab_img[{m_sel, `HUFF_ADDR_EOB}]);
    end
  endfunction

  function automatic void add_block(input logic [15:0] words[$]);
    foreach (words[i]) stim_q.push_back(words[i]);
    blk_len_q.push_back(words.size());
  endfunction

  function automatic void build_stimulus();
    logic [15:0] b[$];
    add_block('{dc_word(5, 0, 0), ac_word(-3), run_word(0, 2), ac_word(7), ac_word(1),
                16'h1000});
    add_block('{dc_word(-100, 1, 0), run_word(1, 3), ac_word(20), run_word(3, 0),
                ac_word(-1), run_word(2, 5), ac_word(2047), 16'h1000});
    add_block('{dc_word(0, 0, 0), ac_word(0), run_word(0, 0), ac_word(-2048), 16'h1000});
    add_block('{dc_word(-2048, 1, 0), run_word(0, 15), ac_word(-15), 16'h1000});
    for (int k = 0; k < 5; k++) begin  // random blocks
      b.delete();
      rnd = xorshift(rnd);
      b.push_back(dc_word(int'(rnd[11:0]), rnd[16], 1'b0));
      for (int j = 0; j < 6; j++) begin
        rnd = xorshift(rnd);
        if (rnd[20]) b.push_back(run_word(rnd[13:12], rnd[3:0]));
        else         b.push_back(ac_word(int'(rnd[11:0])));
      end
      b.push_back(16'h1000);
      add_block(b);
    end
    add_block('{dc_word(300, 1, 1), run_word(1, 4), ac_word(-7), 16'h1000});  // last block
    total_words = stim_q.size();
  endfunction

  // rdy_i draw and check of every token taken at the next edge
  always @(negedge xclk2x) begin : compare_tokens
    logic [19:0] e;
    logic        lb;
    if (load_done) begin
      rdy_rnd = xorshift(rdy_rnd);
      rdy_i   = (rdy_rnd[1:0] != 2'b00);  // about one stall in four
    end
    if (rst_n_i && flush_o && rdy_i) flush_taken = 1'b1;
    if (rst_n_i && dv_o && rdy_i) begin    // token taken at the next edge
      assert (exp_q.size() != 0) else begin
        err_cnt++;
        $display("token accepted while no token was expected, do_o %h", do_o);
      end
      if (exp_q.size() != 0) begin
        e  = exp_q.pop_front();
        lb = exp_lb_q.pop_front();
        check_cnt++;
        assert (do_o == e[15:0]) else begin
          err_cnt++;
          $display("mismatch do_o: got %h expected %h", do_o, e[15:0]);
        end
        assert (dl_o == e[19:16]) else begin
          err_cnt++;
          $display("mismatch dl_o: got %h expected %h", dl_o, e[19:16]);
        end
        assert (last_block_o == lb) else begin
          err_cnt++;
          $display("mismatch last_block_o: got %h expected %h", last_block_o, lb);
        end
      end
    end
  end

  initial begin : watchdog
    wait (total_words != 0);
    #((200 * total_words + 1000) * 10);
    $display("watchdog expired before the test finished");
    $display("errors %0d, tokens checked %0d", err_cnt + 1, check_cnt);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin : drive_stimulus
    int idx;
    xclk2x = 1'b0;
    rst_n_i = 1'b0;
    ds_i = 1'b0;
    di_i = '0;
    rdy_i = 1'b1;
    twe_i = 1'b0;
    ta_i = '0;
    tdi_i = '0;
    build_stimulus();
    repeat (2) @(posedge xclk2x);
    @(negedge xclk2x);
    rst_n_i = 1'b1;
    for (int i = 0; i < 512; i++) begin  // random lengths and codes
      rnd        = xorshift(rnd);
      tab_img[i] = rnd[19:0];
      twe_i      = 1'b1;
      ta_i       = 9'(i);
      tdi_i      = rnd[19:0];
      @(negedge xclk2x);
    end
    twe_i = 1'b0;
    load_done = 1'b1;
    idx = 0;
    foreach (blk_len_q[b]) begin
      for (int j = 0; j < blk_len_q[b]; j++) begin
        ds_i = 1'b1;
        di_i = stim_q[idx];
        model_word(stim_q[idx]);
        idx++;
        @(negedge xclk2x);
        ds_i = 1'b0;
        repeat (3) @(negedge xclk2x);  // one word every 4 cycles
      end
      wait (exp_q.size() == 0);  // whole block drained before the next
      @(negedge xclk2x);
    end
    for (int n = 0; n < 2 && !flush_o; n++) @(negedge xclk2x);  // within 2 cycles
    assert (flush_o) else begin
      err_cnt++;
      $display("flush_o did not rise within 2 cycles of the final token");
    end
    assert (last_block_o) else begin
      err_cnt++;
      $display("last_block_o was low while flush_o was high");
    end
    assert (!dv_o) else begin
      err_cnt++;
      $display("dv_o was high together with flush_o");
    end
    wait (flush_taken);
    @(negedge xclk2x);
    assert (!flush_o) else begin
      err_cnt++;
      $display("mismatch flush_o: got %h expected %h", flush_o, 1'b0);
    end
    assert (!last_block_o) else begin
      err_cnt++;
      $display("mismatch last_block_o: got %h expected %h", last_block_o, 1'b0);
    end
    repeat (5) @(negedge xclk2x);
    $display("errors %0d, tokens checked %0d", err_cnt, check_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+.
huff_word_pkg.sv
huff_code_pkg.sv
huff_in_fifo.sv
huff_sequencer.sv
huff_code_table.sv
huff_out_stage.sv
huffman_enc.sv
huffman_enc_sva.sv
tb_huffman_enc.sv

/* Makefile */
# Verilator build and run of the huffman encoder testbench

TOP = tb_huffman_enc

all: run

build:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f compile.f -Mdir obj_dir -o sim

run: build
	out="$$(./obj_dir/sim)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
